//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f list.f --top-module tb_riscv_core -o sim_tb
	@out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
	parameter int MEM_WORDS = 1024
) (
	input wire logic fetch_req,
	input wire logic [core_pkg::xlen-1:0] fetch_addr,
	input wire logic mem_req,
	input wire logic [core_pkg::xlen-1:0] mem_addr,
	input wire logic mem_we,
	input wire logic [core_pkg::xlen-1:0] mem_wdata,
	input wire logic load_en,
	input wire logic [core_pkg::xlen-1:0] load_addr,
	input wire logic [core_pkg::xlen-1:0] load_data,
	output logic fetch_gnt,
	output logic mem_gnt,
	output logic ram_en,
	output logic ram_we,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output logic [core_pkg::xlen-1:0] ram_wdata
);

	localparam int aw = $clog2(MEM_WORDS);

	// byte address to word index, wrapping around the memory size
	function automatic logic [aw-1:0] to_index(input logic [core_pkg::xlen-1:0] addr);
		logic [31:0] word;
		word = {2'b00, addr[31:2]} % 32'(MEM_WORDS);
		return word[aw-1:0];
	endfunction

	always_comb begin
		fetch_gnt = 1'b0;
		mem_gnt = 1'b0;
		ram_en = 1'b0;
		ram_we = 1'b0;
		ram_addr = to_index(fetch_addr);
		ram_wdata = mem_wdata;
		if (load_en) begin
			// program load owns the memory, no requester is granted
			ram_en = 1'b1;
			ram_we = 1'b1;
			ram_addr = to_index(load_addr);
			ram_wdata = load_data;
		end else if (mem_req) begin
			mem_gnt = 1'b1;
			ram_en = 1'b1;
			ram_we = mem_we;
			ram_addr = to_index(mem_addr);
		end else if (fetch_req) begin
			fetch_gnt = 1'b1;
			ram_en = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

	// data word and register index widths
	localparam int xlen = 32;
	localparam int reg_addr_width = 5;

	// decoded operations, anything unsupported becomes OP_NOP
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_LW,
		OP_SW,
		OP_BEQ
	} op_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_WAIT
	} fetch_state_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_REQ,
		MEM_WAIT
	} mem_state_t;

endpackage

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic id_valid,
	input wire logic [core_pkg::xlen-1:0] id_inst,
	input wire logic [core_pkg::xlen-1:0] id_pc,
	input wire logic ex_stall,
	input wire logic redirect,
	input wire logic wb_en,
	input wire logic [core_pkg::reg_addr_width-1:0] wb_rd,
	input wire logic [core_pkg::xlen-1:0] wb_data,
	output logic id_stall,
	output logic ex_valid,
	output core_pkg::op_t ex_op,
	output logic [core_pkg::reg_addr_width-1:0] ex_rd,
	output logic [core_pkg::xlen-1:0] ex_rs1_val,
	output logic [core_pkg::xlen-1:0] ex_rs2_val,
	output logic [core_pkg::xlen-1:0] ex_imm,
	output logic [core_pkg::xlen-1:0] ex_pc,
	output logic [core_pkg::xlen-1:0] ex_inst
);

	logic [core_pkg::xlen-1:0] regs [32];
	logic [31:0] busy;
	logic [31:0] busy_eff;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [core_pkg::reg_addr_width-1:0] rs1;
	logic [core_pkg::reg_addr_width-1:0] rs2;
	logic [core_pkg::reg_addr_width-1:0] dec_rd;
	core_pkg::op_t dec_op;
	logic [core_pkg::xlen-1:0] dec_imm;
	logic [core_pkg::xlen-1:0] rs1_val;
	logic [core_pkg::xlen-1:0] rs2_val;
	logic uses_rs1;
	logic uses_rs2;
	logic writes_rd;
	logic hazard;
	logic issue;

	assign opcode = id_inst[6:0];
	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];
	assign rs1 = id_inst[19:15];
	assign rs2 = id_inst[24:20];

	always_comb begin
		dec_op = core_pkg::OP_NOP;
		case (opcode)
			7'b0110011: begin
				if (funct7 == 7'b0100000 && funct3 == 3'b000)
					dec_op = core_pkg::OP_SUB;
				else if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: dec_op = core_pkg::OP_ADD;
						3'b111: dec_op = core_pkg::OP_AND;
						3'b110: dec_op = core_pkg::OP_OR;
						3'b100: dec_op = core_pkg::OP_XOR;
						default: dec_op = core_pkg::OP_NOP;
					endcase
				end
			end
			7'b0010011: if (funct3 == 3'b000) dec_op = core_pkg::OP_ADDI;
			7'b0000011: if (funct3 == 3'b010) dec_op = core_pkg::OP_LW;
			7'b0100011: if (funct3 == 3'b010) dec_op = core_pkg::OP_SW;
			7'b1100011: if (funct3 == 3'b000) dec_op = core_pkg::OP_BEQ;
			default: dec_op = core_pkg::OP_NOP;
		endcase
	end

	// S and B formats split the immediate around the rd field
	always_comb begin
		case (dec_op)
			core_pkg::OP_SW:
				dec_imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			core_pkg::OP_BEQ:
				dec_imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
					id_inst[11:8], 1'b0};
			default:
				dec_imm = {{20{id_inst[31]}}, id_inst[31:20]};
		endcase
	end

	assign uses_rs1 = (dec_op != core_pkg::OP_NOP);
	assign uses_rs2 = (dec_op == core_pkg::OP_ADD) || (dec_op == core_pkg::OP_SUB) ||
		(dec_op == core_pkg::OP_AND) || (dec_op == core_pkg::OP_OR) ||
		(dec_op == core_pkg::OP_XOR) || (dec_op == core_pkg::OP_SW) ||
		(dec_op == core_pkg::OP_BEQ);
	assign writes_rd = uses_rs2 ? !(dec_op == core_pkg::OP_SW || dec_op == core_pkg::OP_BEQ) :
		(dec_op == core_pkg::OP_ADDI || dec_op == core_pkg::OP_LW);
	assign dec_rd = writes_rd ? id_inst[11:7] : '0;

	// the register being written back this cycle is no longer pending
	always_comb begin
		busy_eff = busy;
		if (wb_en)
			busy_eff[wb_rd] = 1'b0;
	end

	assign hazard = (uses_rs1 && busy_eff[rs1]) || (uses_rs2 && busy_eff[rs2]) ||
		busy_eff[dec_rd];
	assign id_stall = id_valid && (hazard || ex_stall);
	assign issue = id_valid && !id_stall && !redirect;

	assign rs1_val = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

	always_ff @(posedge clk) begin
		if (wb_en && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= '0;
			ex_valid <= 1'b0;
		end else begin
			// a new writer to the same register wins over the clear
			busy <= busy_eff;
			if (issue && dec_rd != '0)
				busy[dec_rd] <= 1'b1;
			if (redirect)
				ex_valid <= 1'b0;
			else if (!ex_stall)
				ex_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_stall) begin
			ex_op <= dec_op;
			ex_rd <= dec_rd;
			ex_rs1_val <= rs1_val;
			ex_rs2_val <= rs2_val;
			ex_imm <= dec_imm;
			ex_pc <= id_pc;
			ex_inst <= id_inst;
		end
	end

endmodule

`default_nettype wire

//--- hw/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input wire logic clk,
	input wire logic rst,
	input wire logic ex_valid,
	input wire core_pkg::op_t ex_op,
	input wire logic [core_pkg::reg_addr_width-1:0] ex_rd,
	input wire logic [core_pkg::xlen-1:0] ex_rs1_val,
	input wire logic [core_pkg::xlen-1:0] ex_rs2_val,
	input wire logic [core_pkg::xlen-1:0] ex_imm,
	input wire logic [core_pkg::xlen-1:0] ex_pc,
	input wire logic [core_pkg::xlen-1:0] ex_inst,
	input wire logic mem_stall,
	output logic ex_stall,
	output logic redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output logic mem_valid,
	output core_pkg::op_t mem_op,
	output logic [core_pkg::reg_addr_width-1:0] mem_rd,
	output logic [core_pkg::xlen-1:0] mem_result,
	output logic [core_pkg::xlen-1:0] mem_store_data,
	output logic [core_pkg::xlen-1:0] mem_pc,
	output logic [core_pkg::xlen-1:0] mem_inst
);

	logic [core_pkg::xlen-1:0] alu_out;
	logic no_dest;

	always_comb begin
		case (ex_op)
			core_pkg::OP_ADD: alu_out = ex_rs1_val + ex_rs2_val;
			core_pkg::OP_SUB: alu_out = ex_rs1_val - ex_rs2_val;
			core_pkg::OP_AND: alu_out = ex_rs1_val & ex_rs2_val;
			core_pkg::OP_OR: alu_out = ex_rs1_val | ex_rs2_val;
			core_pkg::OP_XOR: alu_out = ex_rs1_val ^ ex_rs2_val;
			// addi and the load/store effective address share the adder
			core_pkg::OP_ADDI, core_pkg::OP_LW, core_pkg::OP_SW:
				alu_out = ex_rs1_val + ex_imm;
			default: alu_out = '0;
		endcase
	end

	assign ex_stall = ex_valid && mem_stall;

	// only fire once the branch actually moves on, so the pulse is single
	assign redirect = ex_valid && !mem_stall && (ex_op == core_pkg::OP_BEQ) &&
		(ex_rs1_val == ex_rs2_val);
	assign redirect_pc = ex_pc + ex_imm;

	assign no_dest = (ex_op == core_pkg::OP_SW) || (ex_op == core_pkg::OP_BEQ);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			mem_valid <= 1'b0;
		else if (!mem_stall)
			mem_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_op <= ex_op;
			mem_rd <= no_dest ? '0 : ex_rd;
			mem_result <= alu_out;
			mem_store_data <= ex_rs2_val;
			mem_pc <= ex_pc;
			mem_inst <= ex_inst;
		end
	end

endmodule

`default_nettype wire

//--- hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch #(
	parameter logic [core_pkg::xlen-1:0] RESET_PC = '0
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic redirect,
	input wire logic [core_pkg::xlen-1:0] redirect_pc,
	input wire logic id_stall,
	output logic bus_req,
	output logic [core_pkg::xlen-1:0] bus_addr,
	input wire logic bus_gnt,
	input wire logic [core_pkg::xlen-1:0] bus_rdata,
	output logic id_valid,
	output logic [core_pkg::xlen-1:0] id_inst,
	output logic [core_pkg::xlen-1:0] id_pc
);

	core_pkg::fetch_state_t state;
	logic [core_pkg::xlen-1:0] pc;
	logic accept;

	assign accept = id_valid && !id_stall;

	// only one instruction in flight, no new request while one is held
	assign bus_req = (state == core_pkg::FETCH_REQ) && !id_valid;
	assign bus_addr = pc;

	// pc stays on the held instruction until decode takes it
	assign id_pc = pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= core_pkg::FETCH_IDLE;
			pc <= RESET_PC;
			id_valid <= 1'b0;
		end else if (redirect) begin
			// outstanding read data is dropped by leaving FETCH_WAIT
			state <= core_pkg::FETCH_REQ;
			pc <= redirect_pc;
			id_valid <= 1'b0;
		end else begin
			case (state)
				core_pkg::FETCH_IDLE: begin
					if (start)
						state <= core_pkg::FETCH_REQ;
				end
				core_pkg::FETCH_REQ: begin
					if (bus_req && bus_gnt)
						state <= core_pkg::FETCH_WAIT;
				end
				core_pkg::FETCH_WAIT: begin
					id_valid <= 1'b1;
					state <= core_pkg::FETCH_REQ;
				end
				default: state <= core_pkg::FETCH_IDLE;
			endcase
			if (accept) begin
				id_valid <= 1'b0;
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_pkg::FETCH_WAIT && !redirect)
			id_inst <= bus_rdata;
	end

endmodule

`default_nettype wire

//--- hw/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb (
	input wire logic clk,
	input wire logic rst,
	input wire logic mem_valid,
	input wire core_pkg::op_t mem_op,
	input wire logic [core_pkg::reg_addr_width-1:0] mem_rd,
	input wire logic [core_pkg::xlen-1:0] mem_result,
	input wire logic [core_pkg::xlen-1:0] mem_store_data,
	input wire logic [core_pkg::xlen-1:0] mem_pc,
	input wire logic [core_pkg::xlen-1:0] mem_inst,
	input wire logic bus_gnt,
	input wire logic [core_pkg::xlen-1:0] bus_rdata,
	output logic mem_stall,
	output logic bus_req,
	output logic [core_pkg::xlen-1:0] bus_addr,
	output logic bus_we,
	output logic [core_pkg::xlen-1:0] bus_wdata,
	output logic wb_en,
	output logic [core_pkg::reg_addr_width-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0] wb_data,
	output logic trace_valid,
	output logic [core_pkg::xlen-1:0] trace_pc,
	output logic [core_pkg::xlen-1:0] trace_inst,
	output logic [core_pkg::reg_addr_width-1:0] trace_rd,
	output logic [core_pkg::xlen-1:0] trace_data
);

	core_pkg::mem_state_t state;
	logic is_load;
	logic is_store;
	logic done;

	assign is_load = (mem_op == core_pkg::OP_LW);
	assign is_store = (mem_op == core_pkg::OP_SW);

	// keep requesting until granted, nothing more once the read is out
	assign bus_req = mem_valid && (is_load || is_store) && (state != core_pkg::MEM_WAIT);
	assign bus_addr = mem_result;
	assign bus_we = mem_valid && is_store;
	assign bus_wdata = mem_store_data;

	always_comb begin
		if (!mem_valid)
			done = 1'b0;
		else if (state == core_pkg::MEM_WAIT)
			done = 1'b1;
		else if (is_store)
			done = bus_gnt;
		else
			done = !is_load;
	end

	assign mem_stall = mem_valid && !done;

	// rd is already zero for x0 and for instructions without a destination
	assign wb_en = done && (mem_rd != '0);
	assign wb_rd = mem_rd;
	assign wb_data = is_load ? bus_rdata : mem_result;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= core_pkg::MEM_IDLE;
			trace_valid <= 1'b0;
		end else begin
			trace_valid <= done;
			case (state)
				core_pkg::MEM_IDLE: begin
					if (bus_req && !bus_gnt)
						state <= core_pkg::MEM_REQ;
					else if (bus_req && is_load)
						state <= core_pkg::MEM_WAIT;
				end
				core_pkg::MEM_REQ: begin
					if (bus_gnt)
						state <= is_load ? core_pkg::MEM_WAIT : core_pkg::MEM_IDLE;
				end
				core_pkg::MEM_WAIT: state <= core_pkg::MEM_IDLE;
				default: state <= core_pkg::MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			trace_pc <= mem_pc;
			trace_inst <= mem_inst;
			trace_rd <= wb_en ? wb_rd : '0;
			trace_data <= wb_en ? wb_data : '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core #(
	parameter logic [core_pkg::xlen-1:0] RESET_PC = '0,
	parameter int MEM_WORDS = 1024
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic load_en,
	input wire logic [core_pkg::xlen-1:0] load_addr,
	input wire logic [core_pkg::xlen-1:0] load_data,
	output logic trace_valid,
	output logic [core_pkg::xlen-1:0] trace_pc,
	output logic [core_pkg::xlen-1:0] trace_inst,
	output logic [core_pkg::reg_addr_width-1:0] trace_rd,
	output logic [core_pkg::xlen-1:0] trace_data
);

	localparam int ram_aw = $clog2(MEM_WORDS);

	// fetch and memory stage bus
	logic fetch_req;
	logic fetch_gnt;
	logic [core_pkg::xlen-1:0] fetch_addr;
	logic mem_req;
	logic mem_gnt;
	logic mem_we;
	logic [core_pkg::xlen-1:0] mem_addr;
	logic [core_pkg::xlen-1:0] mem_wdata;
	logic ram_en;
	logic ram_we;
	logic [ram_aw-1:0] ram_addr;
	logic [core_pkg::xlen-1:0] ram_wdata;
	logic [core_pkg::xlen-1:0] ram_rdata;

	// pipeline
	logic id_valid;
	logic id_stall;
	logic [core_pkg::xlen-1:0] id_inst;
	logic [core_pkg::xlen-1:0] id_pc;
	logic ex_valid;
	logic ex_stall;
	core_pkg::op_t ex_op;
	logic [core_pkg::reg_addr_width-1:0] ex_rd;
	logic [core_pkg::xlen-1:0] ex_rs1_val;
	logic [core_pkg::xlen-1:0] ex_rs2_val;
	logic [core_pkg::xlen-1:0] ex_imm;
	logic [core_pkg::xlen-1:0] ex_pc;
	logic [core_pkg::xlen-1:0] ex_inst;
	logic redirect;
	logic [core_pkg::xlen-1:0] redirect_pc;
	logic mem_valid;
	logic mem_stall;
	core_pkg::op_t mem_op;
	logic [core_pkg::reg_addr_width-1:0] mem_rd;
	logic [core_pkg::xlen-1:0] mem_result;
	logic [core_pkg::xlen-1:0] mem_store_data;
	logic [core_pkg::xlen-1:0] mem_pc;
	logic [core_pkg::xlen-1:0] mem_inst;
	logic wb_en;
	logic [core_pkg::reg_addr_width-1:0] wb_rd;
	logic [core_pkg::xlen-1:0] wb_data;

	fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk),
		.rst(rst),
		.start(start),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.id_stall(id_stall),
		.bus_req(fetch_req),
		.bus_addr(fetch_addr),
		.bus_gnt(fetch_gnt),
		.bus_rdata(ram_rdata),
		.id_valid(id_valid),
		.id_inst(id_inst),
		.id_pc(id_pc)
	);

	decoder u_decoder (
		.clk(clk),
		.rst(rst),
		.id_valid(id_valid),
		.id_inst(id_inst),
		.id_pc(id_pc),
		.ex_stall(ex_stall),
		.redirect(redirect),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.id_stall(id_stall),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_rd(ex_rd),
		.ex_rs1_val(ex_rs1_val),
		.ex_rs2_val(ex_rs2_val),
		.ex_imm(ex_imm),
		.ex_pc(ex_pc),
		.ex_inst(ex_inst)
	);

	execute u_execute (
		.clk(clk),
		.rst(rst),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_rd(ex_rd),
		.ex_rs1_val(ex_rs1_val),
		.ex_rs2_val(ex_rs2_val),
		.ex_imm(ex_imm),
		.ex_pc(ex_pc),
		.ex_inst(ex_inst),
		.mem_stall(mem_stall),
		.ex_stall(ex_stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.mem_valid(mem_valid),
		.mem_op(mem_op),
		.mem_rd(mem_rd),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.mem_pc(mem_pc),
		.mem_inst(mem_inst)
	);

	mem_wb u_mem_wb (
		.clk(clk),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_op(mem_op),
		.mem_rd(mem_rd),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.mem_pc(mem_pc),
		.mem_inst(mem_inst),
		.bus_gnt(mem_gnt),
		.bus_rdata(ram_rdata),
		.mem_stall(mem_stall),
		.bus_req(mem_req),
		.bus_addr(mem_addr),
		.bus_we(mem_we),
		.bus_wdata(mem_wdata),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.trace_valid(trace_valid),
		.trace_pc(trace_pc),
		.trace_inst(trace_inst),
		.trace_rd(trace_rd),
		.trace_data(trace_data)
	);

	bus_arbiter #(.MEM_WORDS(MEM_WORDS)) u_bus_arbiter (
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.fetch_gnt(fetch_gnt),
		.mem_gnt(mem_gnt),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata)
	);

	unified_ram #(.MEM_WORDS(MEM_WORDS)) u_unified_ram (
		.clk(clk),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

endmodule

`default_nettype wire

//--- hw/unified_ram.sv
`timescale 1ns/1ps
`default_nettype none

module unified_ram #(
	parameter int MEM_WORDS = 1024
) (
	input wire logic clk,
	input wire logic ram_en,
	input wire logic ram_we,
	input wire logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	input wire logic [core_pkg::xlen-1:0] ram_wdata,
	output logic [core_pkg::xlen-1:0] ram_rdata
);

	logic [core_pkg::xlen-1:0] mem [MEM_WORDS];

	// read returns the old word on a write, nobody uses it then
	always_ff @(posedge clk) begin
		if (ram_en) begin
			if (ram_we)
				mem[ram_addr] <= ram_wdata;
			ram_rdata <= mem[ram_addr];
		end
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verif
hw/core_pkg.sv
hw/fetch.sv
hw/decoder.sv
hw/execute.sv
hw/mem_wb.sv
hw/bus_arbiter.sv
hw/unified_ram.sv
hw/riscv_core.sv
verif/tb_riscv_core.sv

//--- verif/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam int mem_words = 1024;
// beq x0, x0, 0 spins on itself and marks the end of every program
localparam logic [31:0] halt_inst = 32'h00000063;

logic [31:0] model_regs [32];
logic [31:0] model_mem [mem_words];
logic [31:0] prog [$];

function automatic logic [9:0] word_index(input logic [31:0] addr);
	logic [31:0] w;
	w = (addr >> 2) % 32'(mem_words);
	return w[9:0];
endfunction

function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd, input int rs1,
	input int rs2);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
	input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input int rs1, input int rs2, input int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

// one instruction of the ISA on the model state
task automatic ref_step(input logic [31:0] pc, output logic [31:0] next_pc,
	output logic [4:0] rd_out, output logic [31:0] data_out);
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] res;
	logic w;
	inst = model_mem[word_index(pc)];
	a = model_regs[inst[19:15]];
	b = model_regs[inst[24:20]];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	next_pc = pc + 32'd4;
	res = '0;
	w = 1'b0;
	if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'b0000000) begin
		w = 1'b1;
		if (inst[14:12] == 3'b000)
			res = a + b;
		else if (inst[14:12] == 3'b111)
			res = a & b;
		else if (inst[14:12] == 3'b110)
			res = a | b;
		else if (inst[14:12] == 3'b100)
			res = a ^ b;
		else
			w = 1'b0;
	end else if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'b0100000 &&
		inst[14:12] == 3'b000) begin
		w = 1'b1;
		res = a - b;
	end else if (inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000) begin
		w = 1'b1;
		res = a + imm_i;
	end else if (inst[6:0] == 7'b0000011 && inst[14:12] == 3'b010) begin
		w = 1'b1;
		res = model_mem[word_index(a + imm_i)];
	end else if (inst[6:0] == 7'b0100011 && inst[14:12] == 3'b010) begin
		model_mem[word_index(a + imm_s)] = b;
	end else if (inst[6:0] == 7'b1100011 && inst[14:12] == 3'b000) begin
		if (a == b)
			next_pc = pc + imm_b;
	end
	if (w && inst[11:7] != 5'd0) begin
		model_regs[inst[11:7]] = res;
		rd_out = inst[11:7];
		data_out = res;
	end else begin
		rd_out = '0;
		data_out = '0;
	end
endtask

// x1 holds the data base 0x400 and is never overwritten
task automatic gen_random(input int n);
	int kind;
	int rd;
	int rs1;
	int rs2;
	int off;
	prog.delete();
	prog.push_back(enc_i(7'b0010011, 0, 1, 0, 1024));
	for (int i = 1; i < n - 1; i++) begin
		kind = $urandom_range(0, 10);
		rd = $urandom_range(2, 31);
		rs1 = $urandom_range(0, 31);
		rs2 = $urandom_range(0, 31);
		off = 4 * $urandom_range(0, 63);
		case (kind)
			0: prog.push_back(enc_r(0, 0, rd, rs1, rs2));
			1: prog.push_back(enc_r(32, 0, rd, rs1, rs2));
			2: prog.push_back(enc_r(0, 7, rd, rs1, rs2));
			3: prog.push_back(enc_r(0, 6, rd, rs1, rs2));
			4: prog.push_back(enc_r(0, 4, rd, rs1, rs2));
			5: prog.push_back(enc_i(7'b0010011, 0, rd, rs1, $urandom_range(0, 4095)));
			6: prog.push_back(enc_i(7'b0000011, 2, rd, 1, off));
			7: prog.push_back(enc_s(rs2, 1, off));
			8: begin
				// forward only, and never past the halt
				off = 4 * $urandom_range(2, 4);
				if (i + off / 4 > n - 1)
					off = 4 * (n - 1 - i);
				if ($urandom_range(0, 1) == 0)
					rs2 = rs1;
				prog.push_back(enc_b(rs1, rs2, off));
			end
			9: prog.push_back(32'h12345037);
			default: prog.push_back(enc_i(7'b0010011, 0, rd, 0, $urandom_range(0, 4095)));
		endcase
	end
	prog.push_back(halt_inst);
endtask

`endif

//--- verif/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

	`include "ref_model.svh"

	logic clk;
	logic rst;
	logic start;
	logic load_en;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic trace_valid;
	logic [31:0] trace_pc;
	logic [31:0] trace_inst;
	logic [4:0] trace_rd;
	logic [31:0] trace_data;

	string test_name;
	logic checking;
	logic [31:0] exp_pc [$];
	logic [31:0] exp_inst [$];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];

	riscv_core #(.RESET_PC(32'h0), .MEM_WORDS(mem_words)) dut_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.trace_valid(trace_valid),
		.trace_pc(trace_pc),
		.trace_inst(trace_inst),
		.trace_rd(trace_rd),
		.trace_data(trace_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		report_error($sformatf("CHECK FAILED %s %s expected %h actual %h",
			test_name, what, expected, actual));
	endtask

	// data words outside the program, unique per address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ {addr[15:0], 16'hc35a};
	endfunction

	// compare each retirement with the next expected record
	always @(negedge clk) begin
		logic [31:0] e_pc;
		logic [31:0] e_inst;
		logic [4:0] e_rd;
		logic [31:0] e_data;
		if (checking && trace_valid) begin
			e_pc = exp_pc.pop_front();
			e_inst = exp_inst.pop_front();
			e_rd = exp_rd.pop_front();
			e_data = exp_data.pop_front();
			assert (trace_pc == e_pc) else value_mismatch("pc", e_pc, trace_pc);
			assert (trace_inst == e_inst) else value_mismatch("inst", e_inst, trace_inst);
			assert (trace_rd == e_rd) else value_mismatch("rd", 32'(e_rd), 32'(trace_rd));
			assert (trace_data == e_data) else value_mismatch("data", e_data, trace_data);
			if (exp_pc.size() == 0)
				checking = 1'b0;
		end
	end

	task automatic load_memory();
		logic [31:0] word;
		for (int i = 0; i < mem_words; i++) begin
			word = (i < prog.size()) ? prog[i] : fill_word(32'(i * 4));
			@(negedge clk);
			load_en = 1'b1;
			load_addr = 32'(i * 4);
			load_data = word;
			model_mem[word_index(32'(i * 4))] = word;
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic run_test(input string name);
		logic [31:0] pc;
		logic [31:0] npc;
		logic [4:0] rd;
		logic [31:0] data;
		int steps;
		int limit;
		int cycles;
		test_name = name;
		@(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		load_memory();
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		exp_pc.delete();
		exp_inst.delete();
		exp_rd.delete();
		exp_data.delete();
		pc = '0;
		npc = 32'd4;
		steps = 0;
		while (npc != pc) begin
			exp_inst.push_back(model_mem[word_index(pc)]);
			ref_step(pc, npc, rd, data);
			exp_pc.push_back(pc);
			exp_rd.push_back(rd);
			exp_data.push_back(data);
			if (npc != pc)
				pc = npc;
			steps++;
			if (steps > 5000)
				report_error($sformatf("reference model never reached the halt in %s", name));
		end
		limit = 40 * exp_pc.size() + 200;
		checking = 1'b1;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (checking) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
				report_error($sformatf("timeout in %s, %0d retirements still missing",
					name, exp_pc.size()));
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		checking = 1'b0;
		void'($urandom(32'ha44234ce));

		prog.delete();
		prog.push_back(enc_i(7'b0010011, 0, 1, 0, 32'h5a3));
		prog.push_back(enc_i(7'b0010011, 0, 2, 0, 32'h1c7));
		prog.push_back(enc_r(0, 0, 3, 1, 2));
		prog.push_back(enc_r(32, 0, 4, 1, 2));
		prog.push_back(enc_r(32, 0, 5, 2, 1));
		prog.push_back(enc_r(0, 7, 6, 1, 2));
		prog.push_back(enc_r(0, 6, 7, 1, 2));
		prog.push_back(enc_r(0, 4, 8, 1, 2));
		prog.push_back(halt_inst);
		run_test("alu_ops");

		prog.delete();
		prog.push_back(enc_i(7'b0010011, 0, 1, 0, -1));
		prog.push_back(enc_i(7'b0010011, 0, 2, 1, -2048));
		prog.push_back(enc_i(7'b0010011, 0, 0, 1, 5));
		prog.push_back(enc_r(0, 0, 3, 0, 1));
		prog.push_back(enc_i(7'b0010011, 0, 4, 0, -100));
		prog.push_back(halt_inst);
		run_test("addi_sign");

		prog.delete();
		prog.push_back(enc_i(7'b0010011, 0, 1, 0, 1024));
		prog.push_back(enc_i(7'b0010011, 0, 2, 0, -291));
		prog.push_back(enc_s(2, 1, 8));
		prog.push_back(enc_i(7'b0010011, 0, 3, 0, 77));
		prog.push_back(enc_s(3, 1, 12));
		prog.push_back(enc_i(7'b0000011, 2, 4, 1, 8));
		prog.push_back(enc_i(7'b0000011, 2, 5, 1, 12));
		prog.push_back(enc_i(7'b0000011, 2, 6, 1, 40));
		prog.push_back(enc_i(7'b0000011, 2, 7, 1, -4));
		prog.push_back(halt_inst);
		run_test("load_store");

		prog.delete();
		prog.push_back(enc_i(7'b0010011, 0, 1, 0, 5));
		prog.push_back(enc_i(7'b0010011, 0, 2, 0, 5));
		prog.push_back(enc_b(1, 2, 8));
		prog.push_back(enc_i(7'b0010011, 0, 3, 0, 1));
		prog.push_back(enc_i(7'b0010011, 0, 4, 0, 2));
		prog.push_back(enc_b(1, 0, 8));
		prog.push_back(enc_i(7'b0010011, 0, 5, 0, 3));
		prog.push_back(halt_inst);
		run_test("branch");

		prog.delete();
		prog.push_back(enc_i(7'b0010011, 0, 1, 0, 1));
		repeat (4) prog.push_back(enc_r(0, 0, 1, 1, 1));
		prog.push_back(enc_i(7'b0010011, 0, 2, 0, 1024));
		prog.push_back(enc_s(1, 2, 0));
		prog.push_back(enc_i(7'b0000011, 2, 3, 2, 0));
		prog.push_back(enc_r(0, 0, 4, 3, 1));
		prog.push_back(enc_s(4, 2, 4));
		prog.push_back(enc_i(7'b0000011, 2, 5, 2, 4));
		prog.push_back(enc_r(0, 4, 6, 5, 3));
		prog.push_back(halt_inst);
		run_test("dep_chain");

		gen_random(200);
		run_test("random");

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
